// ==== Bender.yml ====
package:
  name: xirq

sources:
  - files:
      - common/xirq_pkg.sv
      - hdl/xirq_trigger.sv
      - hdl/xirq_pending.sv
      - hdl/xirq_arbiter.sv
      - hdl/xirq_regs.sv
      - hdl/xirq_top.sv
  - target: test
    files:
      - testbench/tb_xirq_top.sv

// ==== all.f ====
common/xirq_pkg.sv
hdl/xirq_trigger.sv
hdl/xirq_pending.sv
hdl/xirq_arbiter.sv
hdl/xirq_regs.sv
hdl/xirq_top.sv
testbench/tb_xirq_top.sv

// ==== common/xirq_pkg.sv ====
/*
 * shared definitions of the external interrupt controller
 * channel count, trigger configuration, register map, vector types, arbiter states
 */

package xirq_pkg;

    // ---------------------------------------------------------------------
    // channel configuration
    // ---------------------------------------------------------------------
    localparam int NUM_CH = 8;                  // platform interrupt lines
    localparam int SRC_W  = 3;                  // bits of a channel index

    // bit set = edge, bit clear = level
    localparam logic [NUM_CH-1:0] TRIG_TYPE = 8'b1111_1100;
    // bit set = high / rising, bit clear = low / falling
    localparam logic [NUM_CH-1:0] TRIG_POL  = 8'b1111_0101;

    // ---------------------------------------------------------------------
    // register window
    // ---------------------------------------------------------------------
    localparam logic [31:0] XIRQ_BASE = 32'hFFFF_FF80; // 16 byte window

    localparam logic [1:0] ENABLE_OFFS  = 2'd0; // channel enable, r/w
    localparam logic [1:0] PENDING_OFFS = 2'd1; // pending, zeros clear
    localparam logic [1:0] SOURCE_OFFS  = 2'd2; // source, write acks

    // ---------------------------------------------------------------------
    // types
    // ---------------------------------------------------------------------
    typedef logic [31:0]       word_t;    // bus data word
    typedef logic [31:0]       addr_t;    // bus address
    typedef logic [NUM_CH-1:0] ch_vec_t;  // one bit per channel
    typedef logic [SRC_W-1:0]  src_idx_t; // channel number

    typedef enum logic {
        ARB_IDLE, // waiting for a pending channel
        ARB_RUN   // irq sent, waiting for source write
    } arb_state_t;

endpackage

// ==== hdl/xirq_arbiter.sv ====
/*
 * fixed priority encoder plus idle/run arbiter
 * lowest pending channel wins, single cpu pulse per source acknowledge
 */

`timescale 1ns/1ps

module xirq_arbiter (
    input  logic               clk_i,     // system clock
    input  logic               rstn_i,    // async reset, active low
    input  xirq_pkg::ch_vec_t  pending_i, // pending buffer
    input  logic               src_ack_i, // source register written
    output xirq_pkg::src_idx_t src_o,     // winning channel, frozen in run
    output logic               cpu_irq_o  // one cycle interrupt to cpu
);

    xirq_pkg::arb_state_t state_q; // idle / run
    xirq_pkg::src_idx_t   src_nxt; // encoder result
    logic                 any_pend; // at least one channel waiting

    // ---------------------------------------------------------------------
    // priority encoder
    // ---------------------------------------------------------------------
    always_comb begin
        src_nxt = '0; // nothing pending reads as channel 0
        // walk downwards so the lowest set bit is the last one taken
        for (int i = xirq_pkg::NUM_CH - 1; i >= 0; i--) begin
            if (pending_i[i]) begin
                src_nxt = xirq_pkg::src_idx_t'(i);
            end
        end
    end

    assign any_pend = |pending_i;

    // ---------------------------------------------------------------------
    // arbiter fsm
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= xirq_pkg::ARB_IDLE;
            src_o     <= '0;
            cpu_irq_o <= 1'b0;
        end else begin
            cpu_irq_o <= 1'b0; // pulse lasts one cycle
            case (state_q)
                xirq_pkg::ARB_IDLE: begin
                    src_o <= src_nxt; // track the current winner
                    if (any_pend) begin
                        cpu_irq_o <= 1'b1;               // fire once
                        state_q   <= xirq_pkg::ARB_RUN;  // source now frozen
                    end
                end
                default: begin
                    if (src_ack_i) begin
                        state_q <= xirq_pkg::ARB_IDLE; // software took it
                    end
                end
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------
    a_irq_single: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cpu_irq_o |=> !cpu_irq_o
    ) else $error("cpu_irq_o high for more than one cycle");

    // the pulse marks exactly the idle to run step
    a_irq_on_entry: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cpu_irq_o |-> (state_q == xirq_pkg::ARB_RUN) && ($past(state_q) == xirq_pkg::ARB_IDLE)
    ) else $error("cpu_irq_o outside idle to run transition");

endmodule

// ==== hdl/xirq_pending.sv ====
/*
 * pending buffer, one sticky bit per channel
 * sets on enabled triggers, clears through the host clear mask
 */

`timescale 1ns/1ps

module xirq_pending (
    input  logic              clk_i,      // system clock
    input  logic              rstn_i,     // async reset, active low
    input  xirq_pkg::ch_vec_t trig_i,     // triggers from the detector
    input  xirq_pkg::ch_vec_t enable_i,   // channel enable register
    input  xirq_pkg::ch_vec_t clr_mask_i, // zero bits clear, all ones when idle
    output xirq_pkg::ch_vec_t pending_o   // to arbiter and read back
);

    xirq_pkg::ch_vec_t set_vec;  // enabled triggers this cycle
    xirq_pkg::ch_vec_t pend_nxt; // next buffer value

    // ---------------------------------------------------------------------
    // update rule
    // ---------------------------------------------------------------------
    assign set_vec  = trig_i & enable_i;
    // clear is applied last, so it beats a trigger in the same cycle
    assign pend_nxt = (pending_o | set_vec) & clr_mask_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_o <= '0;       // nothing pending
        end else begin
            pending_o <= pend_nxt; // sticky until cleared
        end
    end

    // ---------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------
    // a rising bit must trace back to an enabled trigger one cycle before
    a_pend_cause: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (pending_o & ~$past(pending_o) & ~$past(trig_i & enable_i)) == '0
    ) else $error("pending bit set without enabled trigger");

endmodule

// ==== hdl/xirq_regs.sv ====
/*
 * host register port of the interrupt controller
 * window decode, enable register, clear mask, source acknowledge, read data
 */

`timescale 1ns/1ps

module xirq_regs (
    input  logic               clk_i,      // system clock
    input  logic               rstn_i,     // async reset, active low
    input  xirq_pkg::addr_t    addr_i,     // host address
    input  logic               rden_i,     // read strobe
    input  logic               wren_i,     // write strobe
    input  xirq_pkg::word_t    data_i,     // write data
    output xirq_pkg::word_t    data_o,     // read data, zero outside ack
    output logic               ack_o,      // one cycle after a hit
    input  xirq_pkg::ch_vec_t  pending_i,  // pending buffer read back
    input  xirq_pkg::src_idx_t src_i,      // arbiter source index
    output xirq_pkg::ch_vec_t  enable_o,   // channel enable register
    output xirq_pkg::ch_vec_t  clr_mask_o, // zero bits clear pending
    output logic               src_ack_o   // source write pulse
);

    logic       hit;    // address inside window
    logic [1:0] sel;    // word select in window
    logic       wr_hit; // write to this block
    logic       rd_hit; // read from this block
    xirq_pkg::word_t rd_val; // mux of register values

    // ---------------------------------------------------------------------
    // decode
    // ---------------------------------------------------------------------
    assign hit    = (addr_i[31:4] == xirq_pkg::XIRQ_BASE[31:4]);
    assign sel    = addr_i[3:2];     // word offset
    assign wr_hit = hit & wren_i;
    assign rd_hit = hit & rden_i;

    // ---------------------------------------------------------------------
    // write side
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_o   <= '0;    // all channels off
            clr_mask_o <= '1;    // no clear
            src_ack_o  <= 1'b0;
        end else begin
            clr_mask_o <= '1;    // clears last a single cycle
            src_ack_o  <= 1'b0;
            if (wr_hit) begin
                if (sel == xirq_pkg::ENABLE_OFFS) begin
                    enable_o <= data_i[xirq_pkg::NUM_CH-1:0];
                end
                if (sel == xirq_pkg::PENDING_OFFS) begin
                    clr_mask_o <= data_i[xirq_pkg::NUM_CH-1:0]; // zeros clear
                end
                if (sel == xirq_pkg::SOURCE_OFFS) begin
                    src_ack_o <= 1'b1; // data ignored
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // read side
    // ---------------------------------------------------------------------
    always_comb begin
        case (sel)
            xirq_pkg::ENABLE_OFFS:  rd_val = xirq_pkg::word_t'(enable_o);
            xirq_pkg::PENDING_OFFS: rd_val = xirq_pkg::word_t'(pending_i);
            default:                rd_val = xirq_pkg::word_t'(src_i); // word 3 too
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o  <= 1'b0;
            data_o <= '0;
        end else begin
            ack_o  <= rd_hit | wr_hit;       // bus handshake
            data_o <= rd_hit ? rd_val : '0;  // zero unless read ack
        end
    end

    // ---------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------
    a_ack_cause: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ack_o |-> $past(hit & (rden_i | wren_i))
    ) else $error("ack_o without a hit strobe");

    a_no_rd_wr: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(rden_i && wren_i)
    ) else $error("rden_i and wren_i high together");

endmodule

// ==== hdl/xirq_top.sv ====
/*
 * external interrupt controller top level
 * trigger, pending and arbiter stages plus the host register port
 */

`timescale 1ns/1ps

module xirq_top (
    input  logic              clk_i,    // system clock
    input  logic              rstn_i,   // async reset, active low
    input  xirq_pkg::addr_t   addr_i,   // host address
    input  logic              rden_i,   // read strobe
    input  logic              wren_i,   // write strobe
    input  xirq_pkg::word_t   data_i,   // write data
    output xirq_pkg::word_t   data_o,   // read data
    output logic              ack_o,    // transfer acknowledge
    input  xirq_pkg::ch_vec_t xirq_i,   // platform interrupt lines
    output logic              cpu_irq_o // interrupt to cpu
);

    xirq_pkg::ch_vec_t  trig;     // stage 1 to 2
    xirq_pkg::ch_vec_t  pending;  // stage 2 to 3 and read back
    xirq_pkg::ch_vec_t  enable;   // from register port
    xirq_pkg::ch_vec_t  clr_mask; // from register port
    xirq_pkg::src_idx_t src;      // arbiter to register port
    logic               src_ack;  // register port to arbiter

    // ---------------------------------------------------------------------
    // pipeline stages
    // ---------------------------------------------------------------------
    xirq_trigger u_trigger (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .xirq_i (xirq_i),
        .trig_o (trig)
    );

    xirq_pending u_pending (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .trig_i     (trig),
        .enable_i   (enable),
        .clr_mask_i (clr_mask),
        .pending_o  (pending)
    );

    xirq_arbiter u_arbiter (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .pending_i (pending),
        .src_ack_i (src_ack),
        .src_o     (src),
        .cpu_irq_o (cpu_irq_o)
    );

    // ---------------------------------------------------------------------
    // host port
    // ---------------------------------------------------------------------
    xirq_regs u_regs (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .addr_i     (addr_i),
        .rden_i     (rden_i),
        .wren_i     (wren_i),
        .data_i     (data_i),
        .data_o     (data_o),
        .ack_o      (ack_o),
        .pending_i  (pending),
        .src_i      (src),
        .enable_o   (enable),
        .clr_mask_o (clr_mask),
        .src_ack_o  (src_ack)
    );

endmodule

// ==== hdl/xirq_trigger.sv ====
/*
 * two-stage line synchronizer and per-channel trigger detector
 * level or edge kind per channel fixed by the package configuration
 */

`timescale 1ns/1ps

module xirq_trigger (
    input  logic             clk_i,  // system clock
    input  logic             rstn_i, // async reset, active low
    input  xirq_pkg::ch_vec_t xirq_i, // raw platform lines
    output xirq_pkg::ch_vec_t trig_o  // per-channel trigger, one cycle for edges
);

    xirq_pkg::ch_vec_t sync1_q; // first stage, drives level triggers
    xirq_pkg::ch_vec_t sync2_q; // second stage, edge reference

    // ---------------------------------------------------------------------
    // synchronizer
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= xirq_i;  // line sampled here
            sync2_q <= sync1_q; // one cycle older copy
        end
    end

    // ---------------------------------------------------------------------
    // trigger detect
    // ---------------------------------------------------------------------
    for (genvar i = 0; i < xirq_pkg::NUM_CH; i++) begin : g_ch
        // {type, polarity} of this channel
        localparam logic [1:0] KIND = {xirq_pkg::TRIG_TYPE[i], xirq_pkg::TRIG_POL[i]};

        always_comb begin
            case (KIND)
                2'b00:   trig_o[i] = ~sync1_q[i];               // low level
                2'b01:   trig_o[i] = sync1_q[i];                // high level
                2'b10:   trig_o[i] = ~sync1_q[i] & sync2_q[i];  // falling edge
                default: trig_o[i] = sync1_q[i] & ~sync2_q[i];  // rising edge
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // checks
    // ---------------------------------------------------------------------
    // an unknown line would leak x into the pending bits
    a_trig_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(trig_o)
    ) else $error("trig_o carries unknown bits");

endmodule

// ==== testbench/tb_xirq_top.sv ====
/*
 * self-checking testbench of the external interrupt controller
 * replays the case file on the host bus and the interrupt lines, counts cpu pulses
 */

`timescale 1ns/1ps

module tb_xirq_top;

    localparam logic [31:0] win_base   = 32'hFFFF_FF80; // 16 byte register window
    localparam int          cmd_budget = 20;            // timeout cycles per command

    logic               clk_i;
    logic               rstn_i;
    xirq_pkg::addr_t    addr_i;
    logic               rden_i;
    logic               wren_i;
    xirq_pkg::word_t    data_i;
    xirq_pkg::word_t    data_o;
    logic               ack_o;
    xirq_pkg::ch_vec_t  xirq_i;
    logic               cpu_irq_o;

    int cycle_cnt   = 0; // posedges since start
    int cycle_limit = 0; // set after the first pass
    int irq_seen    = 0; // cpu pulses so far
    int irq_base    = 0; // pulse count at the last I command

    // ---------------------------------------------------------------------
    // dut, clock, watchdog
    // ---------------------------------------------------------------------
    xirq_top uut (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .addr_i    (addr_i),
        .rden_i    (rden_i),
        .wren_i    (wren_i),
        .data_i    (data_i),
        .data_o    (data_o),
        .ack_o     (ack_o),
        .xirq_i    (xirq_i),
        .cpu_irq_o (cpu_irq_o)
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i; // 40 ns period

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    // falling edge sees each one-cycle pulse exactly once
    always @(negedge clk_i) begin
        if (rstn_i && cpu_irq_o) begin
            irq_seen <= irq_seen + 1;
        end
    end

    // ---------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------
    function automatic void abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endfunction

    function automatic logic window_hit(input logic [31:0] addr);
        return addr[31:4] == win_base[31:4]; // bits 3:2 pick the word
    endfunction

    function automatic int open_cases();
        int fd;
        fd = $fopen("testbench/xirq_cases.txt", "r");
        assert (fd != 0) else abort_run("case file testbench/xirq_cases.txt could not be opened");
        return fd;
    endfunction

    // fetches the next command and skips comment text
    task automatic read_cmd(input int fd, output logic [7:0] cmd,
                            output logic [31:0] a1, output logic [31:0] a2);
        int         n;
        int         nf;
        int         c;
        logic [7:0] ch;
        logic       found;
        cmd   = 8'd0;
        a1    = '0;
        a2    = '0;
        found = 1'b0;
        while (!found) begin
            n = $fscanf(fd, " %c", ch);
            if (n != 1) begin
                found = 1'b1; // end of file
            end else if (ch == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd); // drop rest of the line
                end
            end else begin
                found = 1'b1;
                cmd   = ch;
                nf    = 0;
                if (ch == "W" || ch == "R") begin
                    nf = 2;
                end else if (ch == "X" || ch == "N" || ch == "I") begin
                    nf = 1;
                end
                assert (nf != 0) else abort_run($sformatf("unknown command '%c' in case file", ch));
                if (nf == 2) begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                end else begin
                    n = $fscanf(fd, "%h", a1);
                end
                assert (n == nf) else abort_run($sformatf("command '%c' lacks a field", ch));
            end
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdat);
        addr_i = addr;
        data_i = wdat;
        wren_i = 1'b1;
        @(negedge clk_i);        // strobe taken at the posedge between
        wren_i = 1'b0;
        data_i = '0;
        assert (ack_o === window_hit(addr)) else
            abort_run($sformatf("** Error: ack_o = %h, expected %h, write to %h",
                                ack_o, window_hit(addr), addr));
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
        addr_i = addr;
        rden_i = 1'b1;
        @(negedge clk_i);
        rden_i = 1'b0;
        assert (ack_o === window_hit(addr)) else
            abort_run($sformatf("** Error: ack_o = %h, expected %h, read of %h",
                                ack_o, window_hit(addr), addr));
        assert (data_o === exp) else
            abort_run($sformatf("** Error: data_o = %h, expected %h, read of %h",
                                data_o, exp, addr));
    endtask

    task automatic drive_lines(input xirq_pkg::ch_vec_t lines);
        xirq_i = lines;
        @(negedge clk_i);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // checked at the posedge so the negedge counter is settled
    task automatic check_irq(input int exp);
        @(posedge clk_i);
        assert (irq_seen - irq_base == exp) else
            abort_run($sformatf("** Error: cpu_irq_o pulse count = %h, expected %h",
                                irq_seen - irq_base, exp));
        irq_base = irq_seen;
        @(negedge clk_i);
    endtask

    // ---------------------------------------------------------------------
    // main sequence
    // ---------------------------------------------------------------------
    initial begin
        int          fd;
        int          n_cmd;
        int          wait_sum;
        logic [7:0]  cmd;
        logic [31:0] a1;
        logic [31:0] a2;
        rstn_i = 1'b0;
        addr_i = '0;
        rden_i = 1'b0;
        wren_i = 1'b0;
        data_i = '0;
        xirq_i = '0;

        // first pass sizes the watchdog
        n_cmd    = 0;
        wait_sum = 0;
        fd = open_cases();
        read_cmd(fd, cmd, a1, a2);
        while (cmd != 8'd0) begin
            n_cmd++;
            if (cmd == "N") begin
                wait_sum += a1;
            end
            read_cmd(fd, cmd, a1, a2);
        end
        $fclose(fd);
        cycle_limit = n_cmd * cmd_budget + wait_sum;

        repeat (3) @(negedge clk_i); // reset for 3 cycles
        rstn_i = 1'b1;

        fd = open_cases();
        read_cmd(fd, cmd, a1, a2);
        while (cmd != 8'd0) begin
            case (cmd)
                "W":     bus_write(a1, a2);
                "R":     bus_read(a1, a2);
                "X":     drive_lines(a1[xirq_pkg::NUM_CH-1:0]);
                "N":     idle_cycles(a1);
                default: check_irq(a1); // I
            endcase
            read_cmd(fd, cmd, a1, a2);
        end
        $fclose(fd);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== testbench/xirq_cases.txt ====
# one command per line, hex fields, text after # ignored
# W addr data | R addr expected | X lines | N cycles | I cpu pulses since last I
X 02                  # ch1 idles high
R ffffff80 00000000   # enable after reset
R ffffff84 00000000   # pending after reset
R ffffff88 00000000   # source after reset
W ffffff80 ffffffff
R ffffff80 000000ff   # masked to 8 channels
W ffffff90 00000000   # miss, no ack
R 00000080 00000000   # miss, no ack
R ffffff80 000000ff   # unchanged by the miss
W ffffff80 0000000f   # channels 0 to 3 on
X 03                  # ch0 high for one cycle
X 02
N 2
R ffffff84 00000001
W ffffff84 fffffffe
W ffffff88 00000000
I 1
X 00                  # ch1 low for one cycle
X 02
N 2
R ffffff84 00000002
R ffffff88 00000001
W ffffff84 fffffffd
W ffffff88 00000000
I 1
X 06                  # ch2 rises and stays high
N 3
R ffffff88 00000002
W ffffff84 fffffffb
W ffffff88 00000000
N 2
R ffffff84 00000000   # edge taken once
X 02                  # ch2 falls, ignored
X 0a                  # ch3 rises, ignored
N 3
R ffffff84 00000000
I 1
X 02                  # ch3 falls
N 3
R ffffff84 00000008
R ffffff8c 00000003   # word 3 reads source
W ffffff84 fffffff7
W ffffff88 00000000
I 1
X 12                  # ch4 rises while disabled
N 3
W ffffff80 000000ff
N 3
R ffffff84 00000000   # missed edge stays lost
X 72                  # ch5 and ch6 rise
N 3
R ffffff84 00000060
W ffffff84 ffffffdf   # clear ch5 only
N 2
R ffffff84 00000040
R ffffff88 00000005
W ffffff84 ffffffbf
W ffffff88 00000000
I 1
X 73                  # ch0 held high
N 2
W ffffff84 fffffffe
N 2
R ffffff84 00000001   # level still active
X 72
W ffffff84 fffffffe
N 2
R ffffff84 00000000
W ffffff88 00000000
I 1
X 02
X a6                  # ch2, ch5, ch7 rise together
N 3
R ffffff88 00000002
R ffffff84 000000a4
N 4
I 1                   # no second pulse before a source write
W ffffff84 fffffffb
W ffffff88 00000000
N 3
R ffffff88 00000005
I 1
W ffffff84 ffffff5f   # clear ch5 and ch7
W ffffff88 00000000
N 3
R ffffff84 00000000
I 0
X 12                  # ch4 rise, pulse three cycles on
I 0
I 0
I 1
I 0
